//--- rtl/obj_config.svh
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// frame table, four words per descriptor
`define OBJ_TABLE_AW   10

// 128 slots per line
`define OBJ_SLOT_BITS  7

// renderer side address, slot index plus word in slot
`define OBJ_LINE_AW    9

// pending host writes held during a build
`define OBJ_WQ_DEPTH   4

// unused slot marker
`define OBJ_FILL_WORD  16'hffff

`endif

//--- rtl/obj_pkg.sv
`include "obj_config.svh"

package obj_pkg;

    // one frame table entry, attr sits at the highest address
    typedef struct packed {
        logic [15:0] attr;
        logic [15:0] code;
        logic [15:0] y;
        logic [15:0] x;
    } obj_desc_t;

    typedef struct packed {
        logic [3:0] tile_m;  // rows minus one
        logic [3:0] tile_n;  // columns minus one
        logic       unused;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_t;

    typedef struct packed {
        logic [`OBJ_TABLE_AW-1:0] addr;
        logic [15:0]              data;
    } host_wr_t;

    // words 0..2 of a line buffer slot
    typedef struct packed {
        logic [15:0] sub;   // 4'd0, vsub, attr[7:0]
        logic [15:0] code;
        logic [15:0] x;
    } line_slot_t;

    typedef enum logic [3:0] {
        idle, read_attr, read_code, read_y, read_x, check,
        wr_sub, wr_code, wr_x, next, fill_sub, fill_code, fill_x
    } build_state_t;

    typedef enum logic [1:0] {grant_none, grant_builder, grant_host} grant_t;

endpackage

//--- rtl/obj_frame_ram.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_frame_ram (
    input  logic                     clk,
    input  logic [`OBJ_TABLE_AW-1:0] addr,
    input  logic                     we,
    input  logic [15:0]              wdata,
    output logic [15:0]              rdata
);

    // descriptor storage, filled by the host
    logic [15:0] mem [2**`OBJ_TABLE_AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // read before write on a shared address
    end

endmodule

//--- rtl/obj_table_arbiter.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_table_arbiter (
    input  logic                     clk,
    input  logic                     rst,
    input  obj_pkg::host_wr_t        host_wr,
    input  logic                     host_wr_en,
    output logic                     host_wr_drop,
    input  logic                     bld_busy,
    input  logic                     bld_rd_en,
    input  logic [`OBJ_TABLE_AW-1:0] bld_rd_addr,
    output logic [15:0]              bld_rd_data,
    output logic [`OBJ_TABLE_AW-1:0] ram_addr,
    output logic                     ram_we,
    output logic [15:0]              ram_wdata,
    input  logic [15:0]              ram_rdata
);
    import obj_pkg::*;

    localparam int PW = $clog2(`OBJ_WQ_DEPTH);

    host_wr_t      queue [`OBJ_WQ_DEPTH];
    logic [PW-1:0] head_ptr;
    logic [PW-1:0] tail_ptr;
    logic [PW:0]   count;
    logic          empty;
    logic          full;
    logic          pop;
    logic          bypass;
    logic          push;
    host_wr_t      head;
    grant_t        grant;

    assign empty = (count == '0);
    assign full  = (count == (PW+1)'(`OBJ_WQ_DEPTH));
    assign head  = empty ? host_wr : queue[head_ptr];  // empty queue passes the new write on

    always_comb begin
        if (bld_rd_en)
            grant = grant_builder;  // builder always wins
        else if (!bld_busy && (!empty || host_wr_en))
            grant = grant_host;
        else
            grant = grant_none;
    end

    assign pop    = (grant == grant_host) && !empty;
    assign bypass = (grant == grant_host) && empty;
    assign push   = host_wr_en && !bypass && (!full || pop);

    assign ram_addr    = (grant == grant_builder) ? bld_rd_addr : head.addr;
    assign ram_we      = (grant == grant_host);
    assign ram_wdata   = head.data;
    assign bld_rd_data = ram_rdata;  // fixed one cycle latency from the RAM

    always_ff @(posedge clk) begin
        if (push) begin
            queue[tail_ptr] <= host_wr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_ptr     <= '0;
            tail_ptr     <= '0;
            count        <= '0;
            host_wr_drop <= 1'b0;
        end else begin
            host_wr_drop <= host_wr_en && !bypass && !push;
            if (push)
                tail_ptr <= tail_ptr + 1'b1;
            if (pop)
                head_ptr <= head_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

endmodule

//--- rtl/obj_line_builder.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_line_builder (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [8:0]               vrender,
    input  logic                     start,
    output logic                     busy,
    output logic                     done,
    output logic                     rd_en,
    output logic [`OBJ_TABLE_AW-1:0] rd_addr,
    input  logic [15:0]              rd_data,
    input  logic [`OBJ_LINE_AW-1:0]  line_addr,
    output logic [15:0]              line_data
);
    import obj_pkg::*;

    // two halves, four words per slot with the last one unused
    logic [15:0] line_buf [2**(`OBJ_LINE_AW+1)];

    build_state_t               state;
    logic [`OBJ_TABLE_AW-3:0]   desc_idx;   // descriptor index, counts down
    logic [`OBJ_SLOT_BITS-1:0]  slot_cnt;
    logic                       first;
    logic [3:0]                 n;          // tile column being emitted
    logic [3:0]                 npos;       // column position, reversed on hflip
    obj_desc_t                  cur_q;
    obj_desc_t                  prev_q;
    obj_desc_t                  cur_desc;
    obj_attr_t                  attr;
    logic                       repeated;
    logic                       last_desc;
    logic                       inzone;
    logic [3:0]                 row_m;
    logic [3:0]                 vsub;
    logic [15:0]                code_mn;
    logic [1:0]                 rd_word;
    logic                       wr_en;
    logic [1:0]                 wr_word;
    logic [15:0]                wr_data;

    assign attr      = obj_attr_t'(cur_q.attr);
    assign cur_desc  = '{attr: cur_q.attr, code: cur_q.code, y: cur_q.y, x: rd_data};
    assign repeated  = (cur_desc == prev_q);
    assign last_desc = (desc_idx == '0);
    assign busy      = (state != idle);

    // row match, at most one of the 16 windows can hold the line
    always_comb begin
        logic [7:0] row_top;
        logic [7:0] row_off;
        inzone = 1'b0;
        row_m  = '0;
        for (int i = 0; i < 16; i++) begin
            row_top = cur_q.y[7:0] + 8'(i * 16);
            row_off = vrender[7:0] - row_top;
            if (i <= attr.tile_m && row_off < 8'd16) begin
                inzone = 1'b1;
                row_m  = 4'(i);
            end
        end
    end

    assign vsub    = (vrender[3:0] - cur_q.y[3:0]) ^ {4{attr.vflip}};
    assign code_mn = {cur_q.code[15:8], cur_q.code[7:4] + row_m, cur_q.code[3:0] + n};

    // attr at word 3 down to x at word 0
    always_comb begin
        case (state)
            read_attr: rd_word = 2'd3;
            read_code: rd_word = 2'd2;
            read_y:    rd_word = 2'd1;
            default:   rd_word = 2'd0;
        endcase
    end

    assign rd_en   = (state == read_attr) || (state == read_code) ||
                     (state == read_y) || (state == read_x);
    assign rd_addr = {desc_idx, rd_word};

    always_comb begin
        wr_en   = 1'b1;
        wr_word = 2'd0;
        wr_data = `OBJ_FILL_WORD;
        case (state)
            wr_sub:    wr_data = {4'd0, vsub, cur_q.attr[7:0]};
            wr_code: begin
                wr_word = 2'd1;
                wr_data = code_mn;
            end
            wr_x: begin
                wr_word = 2'd2;
                wr_data = cur_q.x + {8'd0, npos, 4'd0};
            end
            fill_sub:  wr_word = 2'd0;
            fill_code: wr_word = 2'd1;
            fill_x:    wr_word = 2'd2;
            default:   wr_en   = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_buf[{vrender[0], slot_cnt, wr_word}] <= wr_data;
        end
        line_data <= line_buf[{~vrender[0], line_addr}];  // renderer sees the other half
    end

    // descriptor words land one cycle after their read
    always_ff @(posedge clk) begin
        case (state)
            read_code: cur_q.attr <= rd_data;
            read_y:    cur_q.code <= rd_data;
            read_x:    cur_q.y    <= rd_data;
            check: begin
                cur_q.x <= rd_data;
                prev_q  <= cur_desc;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= idle;
            desc_idx <= '0;
            slot_cnt <= '0;
            first    <= 1'b0;
            n        <= '0;
            npos     <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (start) begin
                        desc_idx <= '1;  // top entry first
                        slot_cnt <= '0;
                        first    <= 1'b1;
                        state    <= read_attr;
                    end
                end
                read_attr: state <= read_code;
                read_code: state <= read_y;
                read_y:    state <= read_x;
                read_x:    state <= check;
                check: begin
                    first <= 1'b0;
                    if ((repeated || !inzone) && !first) begin
                        if (last_desc) begin
                            state <= fill_sub;
                        end else begin
                            desc_idx <= desc_idx - 1'b1;
                            state    <= read_attr;
                        end
                    end else begin
                        n     <= '0;
                        npos  <= attr.hflip ? attr.tile_n : 4'd0;
                        state <= wr_sub;
                    end
                end
                wr_sub:  state <= wr_code;
                wr_code: state <= wr_x;
                wr_x:    state <= next;
                next: begin
                    if (slot_cnt == '1) begin
                        done  <= 1'b1;  // table full, no fill
                        state <= idle;
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                        if (n != attr.tile_n) begin
                            n     <= n + 1'b1;
                            npos  <= attr.hflip ? npos - 1'b1 : npos + 1'b1;
                            state <= wr_sub;
                        end else if (last_desc) begin
                            state <= fill_sub;
                        end else begin
                            desc_idx <= desc_idx - 1'b1;
                            state    <= read_attr;
                        end
                    end
                end
                fill_sub:  state <= fill_code;
                fill_code: state <= fill_x;
                fill_x: begin
                    if (slot_cnt == '1) begin
                        done  <= 1'b1;
                        state <= idle;
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                        state    <= fill_sub;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

//--- rtl/obj_line_top.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_line_top (
    input  logic                    clk,
    input  logic                    rst,
    input  obj_pkg::host_wr_t       host_wr,
    input  logic                    host_wr_en,
    output logic                    host_wr_drop,
    input  logic [8:0]              vrender,
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    input  logic [`OBJ_LINE_AW-1:0] line_addr,
    output logic [15:0]             line_data
);

    logic                     bld_rd_en;
    logic [`OBJ_TABLE_AW-1:0] bld_rd_addr;
    logic [15:0]              bld_rd_data;
    logic [`OBJ_TABLE_AW-1:0] ram_addr;
    logic                     ram_we;
    logic [15:0]              ram_wdata;
    logic [15:0]              ram_rdata;

    obj_frame_ram obj_frame_ram_inst (
        .clk   (clk),
        .addr  (ram_addr),
        .we    (ram_we),
        .wdata (ram_wdata),
        .rdata (ram_rdata)
    );

    obj_table_arbiter obj_table_arbiter_inst (
        .clk          (clk),
        .rst          (rst),
        .host_wr      (host_wr),
        .host_wr_en   (host_wr_en),
        .host_wr_drop (host_wr_drop),
        .bld_busy     (busy),
        .bld_rd_en    (bld_rd_en),
        .bld_rd_addr  (bld_rd_addr),
        .bld_rd_data  (bld_rd_data),
        .ram_addr     (ram_addr),
        .ram_we       (ram_we),
        .ram_wdata    (ram_wdata),
        .ram_rdata    (ram_rdata)
    );

    obj_line_builder obj_line_builder_inst (
        .clk       (clk),
        .rst       (rst),
        .vrender   (vrender),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .rd_en     (bld_rd_en),
        .rd_addr   (bld_rd_addr),
        .rd_data   (bld_rd_data),
        .line_addr (line_addr),
        .line_data (line_data)
    );

endmodule

//--- tb/obj_line_model.svh
`ifndef OBJ_LINE_MODEL_SVH
`define OBJ_LINE_MODEL_SVH

localparam int NUM_DESC  = 2**(`OBJ_TABLE_AW-2);
localparam int NUM_SLOTS = 2**`OBJ_SLOT_BITS;

typedef logic [15:0] frame_tbl_t [2**`OBJ_TABLE_AW];
typedef line_slot_t  line_tbl_t  [NUM_SLOTS];

// four words per entry, attr at the top address
function automatic obj_desc_t desc_at(input frame_tbl_t tbl, input int idx);
    obj_desc_t d;
    d.attr = tbl[idx*4+3];
    d.code = tbl[idx*4+2];
    d.y    = tbl[idx*4+1];
    d.x    = tbl[idx*4];
    return d;
endfunction

// expected line table for line v
function automatic void expected_line(input frame_tbl_t tbl, input logic [8:0] v,
                                      output line_tbl_t exp_tbl);
    obj_desc_t  d;
    obj_desc_t  prev;
    obj_attr_t  a;
    logic [7:0] off;
    logic [3:0] m;
    logic [3:0] vsub;
    logic [3:0] npos;
    logic       keep;
    int         slot;
    slot = 0;
    prev = '0;
    for (int idx = NUM_DESC - 1; idx >= 0 && slot < NUM_SLOTS; idx--) begin
        d    = desc_at(tbl, idx);
        a    = obj_attr_t'(d.attr);
        off  = v[7:0] - d.y[7:0];  // distance below the object top, mod 256
        m    = off[7:4];
        vsub = off[3:0] ^ {4{a.vflip}};
        keep = (idx == NUM_DESC - 1) || ((m <= a.tile_m) && (d != prev));
        prev = d;
        if (keep) begin
            if (m > a.tile_m)
                m = 4'd0;  // top entry kept out of zone, row 0
            for (int n = 0; n <= int'(a.tile_n) && slot < NUM_SLOTS; n++) begin
                npos = a.hflip ? a.tile_n - 4'(n) : 4'(n);
                exp_tbl[slot] = '{
                    sub:  {4'd0, vsub, d.attr[7:0]},
                    code: {d.code[15:8], d.code[7:4] + m, d.code[3:0] + 4'(n)},
                    x:    d.x + {8'd0, npos, 4'd0}
                };
                slot++;
            end
        end
    end
    // unused slots
    for (int s = slot; s < NUM_SLOTS; s++) begin
        exp_tbl[s] = '{sub: `OBJ_FILL_WORD, code: `OBJ_FILL_WORD, x: `OBJ_FILL_WORD};
    end
endfunction

`endif

//--- tb/obj_line_tb.sv
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_line_tb;
    import obj_pkg::*;

    `include "obj_line_model.svh"

    localparam int TIMEOUT = 5000;  // cycles above the longest build
    localparam int LINE_V  = 100;

    logic                    clk;
    logic                    rst;
    host_wr_t                host_wr;
    logic                    host_wr_en;
    logic                    host_wr_drop;
    logic [8:0]              vrender;
    logic                    start;
    logic                    busy;
    logic                    done;
    logic [`OBJ_LINE_AW-1:0] line_addr;
    logic [15:0]             line_data;

    frame_tbl_t model_mem;  // mirror of the frame table
    line_tbl_t  exp_tbl;
    line_tbl_t  exp_next;
    int         errors;
    int         pass_cnt;
    int         fail_cnt;

    obj_line_top obj_line_top_inst (
        .clk          (clk),
        .rst          (rst),
        .host_wr      (host_wr),
        .host_wr_en   (host_wr_en),
        .host_wr_drop (host_wr_drop),
        .vrender      (vrender),
        .start        (start),
        .busy         (busy),
        .done         (done),
        .line_addr    (line_addr),
        .line_data    (line_data)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("TESTS FAILED");
        $finish;
    endtask

    function automatic obj_desc_t make_obj(input logic [3:0] tm, input logic [3:0] tn,
                                           input logic vf, input logic hf, input logic [4:0] pal,
                                           input logic [15:0] code, input logic [15:0] y,
                                           input logic [15:0] x);
        obj_attr_t a;
        a = '{tile_m: tm, tile_n: tn, unused: 1'b0, vflip: vf, hflip: hf, pal: pal};
        return '{attr: a, code: code, y: y, x: x};
    endfunction

    // one write per cycle while the builder is idle
    task automatic write_word(input int addr, input logic [15:0] data);
        @(posedge clk);
        host_wr.addr <= `OBJ_TABLE_AW'(addr);
        host_wr.data <= data;
        host_wr_en   <= 1'b1;
        model_mem[addr] = data;
    endtask

    task automatic release_bus();
        @(posedge clk);
        host_wr_en <= 1'b0;
    endtask

    task automatic put_desc(input int idx, input obj_desc_t d);
        write_word(idx*4+3, d.attr);
        write_word(idx*4+2, d.code);
        write_word(idx*4+1, d.y);
        write_word(idx*4,   d.x);
    endtask

    // blank entries sit far below the test lines
    task automatic clear_table();
        for (int i = 0; i < NUM_DESC; i++)
            put_desc(i, make_obj(4'd0, 4'd0, 1'b0, 1'b0, 5'd0, 16'h0000, 16'h00f0, 16'h0000));
    endtask

    task automatic start_build(input int v);
        @(posedge clk);
        vrender <= 9'(v);
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_busy();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!busy && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!busy)
            abort_run("busy to rise");
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            abort_run("done");
        end else if (busy) begin
            $display("FAIL at %0t: busy still high when done pulsed", $time);
            errors++;
        end
    endtask

    task automatic build_line(input int v);
        start_build(v);
        wait_done();
    endtask

    task automatic read_word(input int addr, output logic [15:0] data);
        @(posedge clk);
        line_addr <= `OBJ_LINE_AW'(addr);
        @(posedge clk);  // one cycle read latency
        @(negedge clk);
        data = line_data;
    endtask

    task automatic check_slot(input int idx, input line_slot_t exp);
        logic [15:0] w0;
        logic [15:0] w1;
        logic [15:0] w2;
        line_slot_t  got;
        read_word(idx*4,   w0);
        read_word(idx*4+1, w1);
        read_word(idx*4+2, w2);
        got = '{sub: w0, code: w1, x: w2};
        if (got !== exp) begin
            $display("FAIL at %0t: slot %0d got %h expected %h", $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_drop(input logic got, input logic exp, input int num);
        if (got !== exp) begin
            $display("FAIL at %0t: drop flag %b on queued write %0d, expected %b",
                     $time, got, num, exp);
            errors++;
        end
    endtask

    // view selects the half the renderer reads
    task automatic check_line(input int view, input line_tbl_t exp);
        @(posedge clk);
        vrender <= 9'(view);
        for (int s = 0; s < NUM_SLOTS; s++)
            check_slot(s, exp[s]);
    endtask

    // host write during a build where num counts writes since its start
    task automatic queued_write(input int addr, input logic [15:0] data, input int num);
        logic exp_drop;
        exp_drop = (num >= `OBJ_WQ_DEPTH);
        @(posedge clk);
        host_wr.addr <= `OBJ_TABLE_AW'(addr);
        host_wr.data <= data;
        host_wr_en   <= 1'b1;
        @(posedge clk);
        host_wr_en <= 1'b0;
        @(negedge clk);
        check_drop(host_wr_drop, exp_drop, num);
        if (!exp_drop)
            model_mem[addr] = data;
    endtask

    task automatic end_test(input string name);
        if (errors == 0) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, errors);
        end
        errors = 0;
    endtask

    initial begin
        obj_desc_t  d;
        obj_desc_t  p;
        logic [3:0] tm;
        void'($urandom(92583));
        clk        = 1'b0;
        rst        = 1'b1;
        host_wr    = '0;
        host_wr_en = 1'b0;
        vrender    = '0;
        start      = 1'b0;
        line_addr  = '0;
        errors     = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        clear_table();
        put_desc(255, make_obj(4'd0, 4'd0, 1'b0, 1'b0, 5'd5, 16'h1230, 16'd96, 16'd200));
        put_desc(254, make_obj(4'd0, 4'd0, 1'b0, 1'b0, 5'd7, 16'h4560, 16'h0020, 16'd50));
        release_bus();
        expected_line(model_mem, LINE_V, exp_tbl);
        build_line(LINE_V);
        check_line(LINE_V + 1, exp_tbl);
        end_test("single objects");

        clear_table();
        for (int i = 0; i < 6; i++) begin
            tm = 4'($urandom);
            d  = make_obj(tm, 4'($urandom_range(3)), 1'($urandom), 1'($urandom), 5'($urandom),
                          16'($urandom), 16'($urandom), 16'($urandom));
            if (i % 2 == 0)  // pull every other object into the zone
                d.y[7:0] = 8'(LINE_V - 16 * ($urandom % (int'(tm) + 1)) - $urandom_range(15));
            put_desc(255 - i, d);
        end
        release_bus();
        expected_line(model_mem, LINE_V, exp_tbl);
        build_line(LINE_V);
        check_line(LINE_V + 1, exp_tbl);
        end_test("multi-tile flips");

        clear_table();
        d = make_obj(4'd0, 4'd1, 1'b0, 1'b1, 5'd3, 16'h0a10, 16'h0020, 16'd30);  // out of zone
        p = make_obj(4'd2, 4'd2, 1'b1, 1'b0, 5'd9, 16'h2b40, 16'd80, 16'd120);
        put_desc(255, d);
        put_desc(254, d);
        put_desc(253, p);
        put_desc(252, p);
        put_desc(251, p);
        release_bus();
        expected_line(model_mem, LINE_V, exp_tbl);
        build_line(LINE_V);
        check_line(LINE_V + 1, exp_tbl);
        end_test("repeated descriptors");

        clear_table();
        for (int i = 0; i < 9; i++)  // 144 tiles wanted
            put_desc(255 - i, make_obj(4'd1, 4'd15, 1'($urandom), 1'($urandom), 5'(i),
                                       16'(i * 257), 16'd90, 16'(i * 40)));
        release_bus();
        expected_line(model_mem, LINE_V, exp_tbl);
        build_line(LINE_V);
        check_line(LINE_V + 1, exp_tbl);
        end_test("slot overflow");

        clear_table();
        put_desc(255, make_obj(4'd0, 4'd1, 1'b0, 1'b0, 5'd1, 16'h0100, 16'd96, 16'd10));
        release_bus();
        expected_line(model_mem, LINE_V, exp_tbl);
        start_build(LINE_V);
        wait_busy();
        d = make_obj(4'd0, 4'd2, 1'b0, 1'b1, 5'd2, 16'h0200, 16'd98, 16'd64);
        queued_write(254*4+3, d.attr, 0);
        queued_write(254*4+2, d.code, 1);
        queued_write(254*4+1, d.y, 2);
        queued_write(254*4,   d.x, 3);
        queued_write(255*4,   16'd500, 4);  // queue full from here on
        queued_write(255*4+2, 16'h0fff, 5);
        wait_done();
        check_line(LINE_V + 1, exp_tbl);
        repeat (`OBJ_WQ_DEPTH + 1) @(posedge clk);  // drain of the held writes
        expected_line(model_mem, LINE_V, exp_tbl);
        build_line(LINE_V);
        check_line(LINE_V + 1, exp_tbl);
        end_test("shared memory");

        clear_table();
        put_desc(255, make_obj(4'd3, 4'd1, 1'b1, 1'b0, 5'd4, 16'h3300, 16'd70, 16'd16));
        put_desc(254, make_obj(4'd0, 4'd0, 1'b0, 1'b0, 5'd6, 16'h4400, 16'd101, 16'd80));
        release_bus();
        expected_line(model_mem, LINE_V, exp_tbl);
        expected_line(model_mem, LINE_V + 1, exp_next);
        build_line(LINE_V);
        build_line(LINE_V + 1);
        check_line(LINE_V + 1, exp_tbl);   // even half
        check_line(LINE_V + 2, exp_next);  // odd half
        end_test("ping-pong buffers");

        $display("summary: %0d ok, %0d failing", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+rtl
+incdir+tb
rtl/obj_pkg.sv
rtl/obj_frame_ram.sv
rtl/obj_table_arbiter.sv
rtl/obj_line_builder.sv
rtl/obj_line_top.sv
tb/obj_line_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f sources.f --top-module obj_line_tb -o obj_line_sim
out=$(./obj_dir/obj_line_sim)
echo "$out"

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
else
    exit 1
fi
